/* cpu_pkg.sv */
// cpu_pkg widths, opcodes, alu operations and decoded control for the rv32i pipeline
package cpu_pkg;

  // datapath sizes
  localparam int xlen            = 32;
  localparam int reg_addr_w      = 5;
  localparam int imem_depth_log2 = 8;   // 256 words
  localparam int dmem_depth_log2 = 8;   // 256 words

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // a0 value that turns ecall into a halt
  localparam word_t halt_code = word_t'(10);

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,   // r-type alu
    opc_op_imm = 7'b0010011,   // i-type alu
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011    // ecall only
  } opcode_e;

  // alu operations, compares only drive the branch condition
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_eq  = 4'd6,   // beq
    alu_ne  = 4'd7,   // bne
    alu_lt  = 4'd8,   // blt signed
    alu_ge  = 4'd9    // bge signed
  } alu_op_e;

  // decoded control carried down the pipe
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;   // writeback takes load data
    logic    alu_src;      // operand b from immediate
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    pc_to_reg;    // link write of pc plus 4
    alu_op_e alu_op;
  } ctrl_t;

endpackage

/* cpu_if.sv */
// pipeline interfaces for the ex/mem register and the writeback bus
`timescale 1ns/1ps

interface ex_mem_if;
  logic              mem_read;
  logic              mem_write;
  logic              reg_write;
  logic              mem_to_reg;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::word_t    alu_out;      // address, alu result or link value
  cpu_pkg::word_t    store_data;
  logic              halt;

  // execute owns the register
  modport ex (output mem_read, mem_write, reg_write, mem_to_reg,
              output rd, alu_out, store_data, halt);
  // memory stage consumes it
  modport mem (input mem_read, mem_write, reg_write, mem_to_reg,
               input rd, alu_out, store_data, halt);
  // decode watches for a0 writes in flight
  modport dec (input rd, reg_write);
endinterface

interface wb_if;
  logic              reg_write;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::word_t    data;

  // driven from mem/wb
  modport src (output reg_write, rd, data);
  // register file write port
  modport rf (input reg_write, rd, data);
  // forwarding path into the alu
  modport fwd (input reg_write, rd, data);
endinterface

/* fetch_stage.sv */
// fetch stage with pc, instruction memory, load port and the if/id register
`timescale 1ns/1ps

module fetch_stage (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   imem_we,
  input  logic [cpu_pkg::imem_depth_log2-1:0]    imem_addr,
  input  cpu_pkg::word_t                         imem_data,
  input  logic                                   stall,
  input  logic                                   halt_req,
  input  logic                                   redirect,
  input  cpu_pkg::word_t                         target,
  output cpu_pkg::word_t                         if_pc,
  output cpu_pkg::word_t                         if_inst
);

  cpu_pkg::word_t imem [2**cpu_pkg::imem_depth_log2];
  cpu_pkg::word_t pc;
  logic           halting;     // sticky once the halting ecall passes decode
  logic           hold_fetch;

  assign hold_fetch = halt_req | halting;

  // program load port, tb uses it under reset
  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      halting <= 1'b0;
      if_inst <= '0;             // zero word decodes to no control
    end else begin
      if (halt_req) halting <= 1'b1;
      if (redirect) begin         // taken branch or jump from execute
        pc      <= target;
        if_inst <= '0;
      end else if (hold_fetch) begin
        if_inst <= '0;            // pc frozen, bubbles only
      end else if (!stall) begin
        pc      <= pc + cpu_pkg::word_t'(4);   // predict not taken
        if_pc   <= pc;
        if_inst <= imem[pc[cpu_pkg::imem_depth_log2+1:2]];
      end
      // stall keeps pc and if/id as they are
    end
  end

endmodule

/* decode_stage.sv */
// decode stage with control, immediates, register file, hazards, halt detect and id/ex
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,
  input  cpu_pkg::word_t    if_pc,
  input  cpu_pkg::word_t    if_inst,
  wb_if.rf                  wb,
  ex_mem_if.dec             exm,
  input  cpu_pkg::reg_idx_t dbg_addr,
  output cpu_pkg::word_t    dbg_data,
  output logic              stall,
  output logic              halt_req,
  output cpu_pkg::ctrl_t    id_ctrl,
  output cpu_pkg::word_t    id_pc,
  output cpu_pkg::word_t    id_rs1_val,
  output cpu_pkg::word_t    id_rs2_val,
  output cpu_pkg::word_t    id_imm,
  output cpu_pkg::reg_idx_t id_rs1,
  output cpu_pkg::reg_idx_t id_rs2,
  output cpu_pkg::reg_idx_t id_rd,
  output logic              id_halt
);

  cpu_pkg::word_t    regs [2**cpu_pkg::reg_addr_w];
  cpu_pkg::ctrl_t    ctrl;
  cpu_pkg::word_t    imm;
  cpu_pkg::word_t    a0_val;
  cpu_pkg::reg_idx_t rs1, rs2, rd;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              uses_rs1, uses_rs2;
  logic              is_ecall, load_use, ecall_wait;

  assign opcode = if_inst[6:0];
  assign funct3 = if_inst[14:12];
  assign rs1    = if_inst[19:15];
  assign rs2    = if_inst[24:20];
  assign rd     = if_inst[11:7];

  // read with write-before-read bypass and x0 hardwired to zero
  function automatic cpu_pkg::word_t rf_read(input cpu_pkg::reg_idx_t a);
    if (a == '0) return '0;
    if (wb.reg_write && wb.rd == a) return wb.data;
    return regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (wb.reg_write && wb.rd != '0) regs[wb.rd] <= wb.data;
  end

  always_comb begin
    dbg_data = rf_read(dbg_addr);
    a0_val   = rf_read(cpu_pkg::reg_idx_t'(10));   // a0 for ecall
  end

  // main control
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = cpu_pkg::alu_add;
    is_ecall    = 1'b0;
    case (opcode)
      cpu_pkg::opc_op:     ctrl.reg_write = 1'b1;
      cpu_pkg::opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      cpu_pkg::opc_load: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;   // base plus offset
      end
      cpu_pkg::opc_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      cpu_pkg::opc_branch: ctrl.is_branch = 1'b1;
      cpu_pkg::opc_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.pc_to_reg = 1'b1;
      end
      cpu_pkg::opc_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      cpu_pkg::opc_system: is_ecall = (funct3 == 3'b000) && (if_inst[31:20] == 12'h000);
      default: ;                  // unknown opcode or bubble has no side effects
    endcase
    // alu operation from funct fields
    if (opcode == cpu_pkg::opc_op || opcode == cpu_pkg::opc_op_imm) begin
      case (funct3)
        3'b000: ctrl.alu_op = (opcode == cpu_pkg::opc_op && if_inst[30]) ?
                              cpu_pkg::alu_sub : cpu_pkg::alu_add;
        3'b010: ctrl.alu_op = cpu_pkg::alu_slt;
        3'b100: ctrl.alu_op = cpu_pkg::alu_xor;
        3'b110: ctrl.alu_op = cpu_pkg::alu_or;
        3'b111: ctrl.alu_op = cpu_pkg::alu_and;
        default: ctrl.alu_op = cpu_pkg::alu_add;
      endcase
    end else if (opcode == cpu_pkg::opc_branch) begin
      case (funct3)
        3'b001:  ctrl.alu_op = cpu_pkg::alu_ne;
        3'b100:  ctrl.alu_op = cpu_pkg::alu_lt;
        3'b101:  ctrl.alu_op = cpu_pkg::alu_ge;
        default: ctrl.alu_op = cpu_pkg::alu_eq;
      endcase
    end
  end

  // immediate generation with i-type as the default
  always_comb begin
    case (opcode)
      cpu_pkg::opc_store:  imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      cpu_pkg::opc_branch: imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                                  if_inst[30:25], if_inst[11:8], 1'b0};
      cpu_pkg::opc_jal:    imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12],
                                  if_inst[20], if_inst[30:21], 1'b0};
      default:             imm = {{20{if_inst[31]}}, if_inst[31:20]};
    endcase
  end

  assign uses_rs1 = (opcode != cpu_pkg::opc_jal) && (opcode != cpu_pkg::opc_system);
  assign uses_rs2 = (opcode == cpu_pkg::opc_op) || (opcode == cpu_pkg::opc_store) ||
                    (opcode == cpu_pkg::opc_branch);

  // load in id/ex feeding this instruction
  assign load_use = id_ctrl.mem_read && id_rd != '0 &&
                    ((uses_rs1 && id_rd == rs1) || (uses_rs2 && id_rd == rs2));
  // a0 write still ahead of the ecall
  assign ecall_wait = is_ecall &&
                      ((id_ctrl.reg_write && id_rd == cpu_pkg::reg_idx_t'(10)) ||
                       (exm.reg_write && exm.rd == cpu_pkg::reg_idx_t'(10)));
  assign stall    = load_use | ecall_wait;
  assign halt_req = is_ecall && !ecall_wait && !flush && (a0_val == cpu_pkg::halt_code);

  // id/ex register
  always_ff @(posedge clk) begin
    if (reset || flush || stall) begin
      id_ctrl <= '0;              // bubble
      id_halt <= 1'b0;
    end else begin
      id_ctrl <= ctrl;
      id_halt <= halt_req;
    end
    id_pc      <= if_pc;
    id_rs1_val <= rf_read(rs1);
    id_rs2_val <= rf_read(rs2);
    id_imm     <= imm;
    id_rs1     <= rs1;
    id_rs2     <= rs2;
    id_rd      <= rd;
  end

endmodule

/* execute_stage.sv */
// execute stage with forwarding, alu, branch resolution, redirect and ex/mem register
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::ctrl_t    id_ctrl,
  input  cpu_pkg::word_t    id_pc,
  input  cpu_pkg::word_t    id_rs1_val,
  input  cpu_pkg::word_t    id_rs2_val,
  input  cpu_pkg::word_t    id_imm,
  input  cpu_pkg::reg_idx_t id_rs1,
  input  cpu_pkg::reg_idx_t id_rs2,
  input  cpu_pkg::reg_idx_t id_rd,
  input  logic              id_halt,
  wb_if.fwd                 wb,
  ex_mem_if.ex              exm,
  output logic              redirect,
  output logic              flush,
  output cpu_pkg::word_t    target
);

  cpu_pkg::word_t fwd_a, fwd_b;      // forwarded register operands
  cpu_pkg::word_t op_b;
  cpu_pkg::word_t alu_res, ex_result;
  cpu_pkg::word_t jalr_sum;
  logic           bcond;

  // newest producer wins, ex/mem before mem/wb
  always_comb begin
    if (exm.reg_write && exm.rd != '0 && exm.rd == id_rs1)
      fwd_a = exm.alu_out;
    else if (wb.reg_write && wb.rd != '0 && wb.rd == id_rs1)
      fwd_a = wb.data;
    else
      fwd_a = id_rs1_val;
    if (exm.reg_write && exm.rd != '0 && exm.rd == id_rs2)
      fwd_b = exm.alu_out;
    else if (wb.reg_write && wb.rd != '0 && wb.rd == id_rs2)
      fwd_b = wb.data;
    else
      fwd_b = id_rs2_val;
  end

  assign op_b = id_ctrl.alu_src ? id_imm : fwd_b;

  always_comb begin
    alu_res = '0;
    bcond   = 1'b0;
    case (id_ctrl.alu_op)
      cpu_pkg::alu_add: alu_res = fwd_a + op_b;
      cpu_pkg::alu_sub: alu_res = fwd_a - op_b;
      cpu_pkg::alu_and: alu_res = fwd_a & op_b;
      cpu_pkg::alu_or:  alu_res = fwd_a | op_b;
      cpu_pkg::alu_xor: alu_res = fwd_a ^ op_b;
      cpu_pkg::alu_slt: alu_res = {{(cpu_pkg::xlen-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
      cpu_pkg::alu_eq:  bcond = (fwd_a == op_b);
      cpu_pkg::alu_ne:  bcond = (fwd_a != op_b);
      cpu_pkg::alu_lt:  bcond = ($signed(fwd_a) < $signed(op_b));
      cpu_pkg::alu_ge:  bcond = ($signed(fwd_a) >= $signed(op_b));
      default:          alu_res = fwd_a + op_b;
    endcase
  end

  // link value replaces the alu result for jal and jalr
  assign ex_result = id_ctrl.pc_to_reg ? id_pc + cpu_pkg::word_t'(4) : alu_res;

  assign jalr_sum = fwd_a + id_imm;
  assign target   = id_ctrl.is_jalr ? {jalr_sum[cpu_pkg::xlen-1:1], 1'b0}   // lsb cleared
                                    : id_pc + id_imm;
  assign redirect = id_ctrl.is_jal | id_ctrl.is_jalr | (id_ctrl.is_branch & bcond);
  assign flush    = redirect;      // kills if/id and id/ex contents

  // ex/mem register
  always_ff @(posedge clk) begin
    if (reset) begin
      exm.mem_read   <= 1'b0;
      exm.mem_write  <= 1'b0;
      exm.reg_write  <= 1'b0;
      exm.mem_to_reg <= 1'b0;
      exm.halt       <= 1'b0;
    end else begin
      exm.mem_read   <= id_ctrl.mem_read;
      exm.mem_write  <= id_ctrl.mem_write;
      exm.reg_write  <= id_ctrl.reg_write;
      exm.mem_to_reg <= id_ctrl.mem_to_reg;
      exm.halt       <= id_halt;
    end
    exm.rd         <= id_rd;
    exm.alu_out    <= ex_result;
    exm.store_data <= fwd_b;       // forwarded rs2 for sw
  end

endmodule

/* memory_stage.sv */
// memory stage with data memory, mem/wb register, writeback select and halt latch
`timescale 1ns/1ps

module memory_stage (
  input  logic  clk,
  input  logic  reset,
  ex_mem_if.mem exm,
  wb_if.src     wb,
  output logic  halted
);

  cpu_pkg::word_t    dmem [2**cpu_pkg::dmem_depth_log2];
  cpu_pkg::word_t    load_data;
  logic [cpu_pkg::dmem_depth_log2-1:0] widx;   // word index

  // mem/wb contents
  logic              mwb_reg_write;
  logic              mwb_mem_to_reg;
  logic              mwb_halt;
  cpu_pkg::reg_idx_t mwb_rd;
  cpu_pkg::word_t    mwb_alu;
  cpu_pkg::word_t    mwb_load;
  logic              halted_q;

  assign widx      = exm.alu_out[cpu_pkg::dmem_depth_log2+1:2];
  assign load_data = exm.mem_read ? dmem[widx] : '0;   // single cycle read

  always_ff @(posedge clk) begin
    if (exm.mem_write) dmem[widx] <= exm.store_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mwb_reg_write  <= 1'b0;
      mwb_mem_to_reg <= 1'b0;
      mwb_halt       <= 1'b0;
      halted_q       <= 1'b0;
    end else begin
      mwb_reg_write  <= exm.reg_write;
      mwb_mem_to_reg <= exm.mem_to_reg;
      mwb_halt       <= exm.halt;
      halted_q       <= halted_q | mwb_halt;   // sticky until reset
    end
    mwb_rd   <= exm.rd;
    mwb_alu  <= exm.alu_out;
    mwb_load <= load_data;
  end

  // writeback bus
  assign wb.reg_write = mwb_reg_write;
  assign wb.rd        = mwb_rd;
  assign wb.data      = mwb_mem_to_reg ? mwb_load : mwb_alu;
  assign halted       = halted_q;

endmodule

/* cpu.sv */
// rv32i five stage pipeline top level with load and debug ports
`timescale 1ns/1ps

module cpu (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                imem_we,     // program load
  input  logic [cpu_pkg::imem_depth_log2-1:0] imem_addr,   // word address
  input  cpu_pkg::word_t                      imem_data,
  input  cpu_pkg::reg_idx_t                   dbg_addr,
  output cpu_pkg::word_t                      dbg_data,
  output logic                                halted
);

  ex_mem_if exm ();
  wb_if     wb ();

  // fetch to decode
  cpu_pkg::word_t    if_pc, if_inst;
  // decode hazard outputs
  logic              stall, halt_req;
  // id/ex register contents
  cpu_pkg::ctrl_t    id_ctrl;
  cpu_pkg::word_t    id_pc, id_rs1_val, id_rs2_val, id_imm;
  cpu_pkg::reg_idx_t id_rs1, id_rs2, id_rd;
  logic              id_halt;
  // execute redirect
  logic              redirect, flush;
  cpu_pkg::word_t    target;

  fetch_stage i_fetch (
    .clk, .reset,
    .imem_we, .imem_addr, .imem_data,
    .stall, .halt_req, .redirect, .target,
    .if_pc, .if_inst
  );

  decode_stage i_decode (
    .clk, .reset, .flush,
    .if_pc, .if_inst,
    .wb (wb.rf), .exm (exm.dec),
    .dbg_addr, .dbg_data,
    .stall, .halt_req,
    .id_ctrl, .id_pc, .id_rs1_val, .id_rs2_val, .id_imm,
    .id_rs1, .id_rs2, .id_rd, .id_halt
  );

  execute_stage i_execute (
    .clk, .reset,
    .id_ctrl, .id_pc, .id_rs1_val, .id_rs2_val, .id_imm,
    .id_rs1, .id_rs2, .id_rd, .id_halt,
    .wb (wb.fwd), .exm (exm.ex),
    .redirect, .flush, .target
  );

  memory_stage i_memory (
    .clk, .reset,
    .exm (exm.mem), .wb (wb.src),
    .halted
  );

endmodule

/* cpu_sva.sv */
// assertions on halt and program load behavior of the cpu top level
`timescale 1ns/1ps

module cpu_sva (
  input logic clk,
  input logic reset,
  input logic imem_we,
  input logic halted
);

  // reset clears the halt flag
  halted_cleared: assert property (@(posedge clk) reset |=> !halted)
    else $error("halted high after reset");

  // sticky until reset
  halted_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(reset))
    else $error("halted dropped without reset");

  // program load only while the core is held
  load_in_reset: assert property (@(posedge clk) imem_we |-> reset)
    else $error("imem write outside reset");

endmodule

bind cpu cpu_sva i_cpu_sva (
  .clk     (clk),
  .reset   (reset),
  .imem_we (imem_we),
  .halted  (halted)
);

/* tb_programs.svh */
// test table for the rv32i pipeline, programs with expected register values
localparam int n_tests   = 5;
localparam int max_words = 16;

string       names   [n_tests];
logic [31:0] prog    [n_tests][max_words];
int          n_words [n_tests];
int          budget  [n_tests];
int          n_exp   [n_tests];
int          exp_reg [n_tests][4];
logic [31:0] exp_val [n_tests][4];

task automatic put(input int t, input logic [31:0] w);
  prog[t][n_words[t]] = w;
  n_words[t]++;
endtask

task automatic expect_reg(input int t, input int r, input logic [31:0] v);
  exp_reg[t][n_exp[t]] = r;
  exp_val[t][n_exp[t]] = v;
  n_exp[t]++;
endtask

task automatic fill_table();
  for (int t = 0; t < n_tests; t++) begin
    n_words[t] = 0;
    n_exp[t]   = 0;
    budget[t]  = 100;
    for (int i = 0; i < max_words; i++) prog[t][i] = 32'h0;   // zero word is a bubble
  end
  // dependent alu chain, forwarding from ex/mem and mem/wb
  names[0] = "alu_chain";
  put(0, addi(1, 0, 5));
  put(0, addi(2, 1, 3));                 // x2 = 8
  put(0, r_type(0, 0, 3, 1, 2));         // add x3 = 13
  put(0, r_type(32, 0, 4, 3, 1));        // sub x4 = 8
  put(0, r_type(0, 7, 5, 4, 3));         // and x5 = 8
  put(0, r_type(0, 6, 6, 5, 1));         // or  x6 = 13
  put(0, r_type(0, 4, 7, 6, 2));         // xor x7 = 5
  put(0, r_type(0, 2, 8, 4, 6));         // slt x8 = 1
  put(0, i_type(19, 7, 9, 7, 4));        // andi x9 = 4
  put(0, i_type(19, 6, 11, 9, 3));       // ori x11 = 7
  put(0, addi(10, 0, 10));
  put(0, ecall_word);
  expect_reg(0, 3, 32'd13);
  expect_reg(0, 7, 32'd5);
  expect_reg(0, 8, 32'd1);
  expect_reg(0, 11, 32'd7);
  // store, load and an immediate consumer of the load
  names[1] = "load_use";
  put(1, addi(1, 0, 42));
  put(1, addi(2, 0, 8));
  put(1, s_type(1, 2, 4));               // sw x1, 4(x2)
  put(1, i_type(3, 2, 3, 2, 4));         // lw x3, 4(x2)
  put(1, r_type(0, 0, 4, 3, 1));         // add x4 = x3 + x1
  put(1, addi(10, 0, 10));
  put(1, ecall_word);
  expect_reg(1, 3, 32'd42);
  expect_reg(1, 4, 32'd84);
  // branches, taken and not taken, signed compares
  names[2] = "branches";
  put(2, addi(5, 0, 7));
  put(2, addi(1, 0, 3));
  put(2, addi(2, 0, 3));
  put(2, b_type(0, 1, 2, 8));            // beq taken
  put(2, addi(5, 0, 99));                // skipped
  put(2, b_type(1, 1, 2, 8));            // bne not taken
  put(2, addi(6, 0, 1));
  put(2, addi(3, 0, -4));
  put(2, b_type(4, 3, 1, 8));            // blt -4 < 3 taken
  put(2, addi(6, 0, 50));                // skipped
  put(2, b_type(5, 1, 3, 8));            // bge 3 >= -4 taken
  put(2, addi(6, 0, 60));                // skipped
  put(2, b_type(5, 3, 1, 8));            // bge -4 >= 3 not taken
  put(2, addi(7, 0, 9));
  put(2, addi(10, 0, 10));
  put(2, ecall_word);
  expect_reg(2, 5, 32'd7);
  expect_reg(2, 6, 32'd1);
  expect_reg(2, 7, 32'd9);
  expect_reg(2, 3, 32'hffff_fffc);
  // jal link and jalr through the link register
  names[3] = "jumps";
  put(3, addi(1, 0, 1));
  put(3, j_type(2, 8));                  // jal x2, +8, link 8
  put(3, addi(1, 0, 77));                // skipped
  put(3, addi(3, 0, 5));
  put(3, i_type(103, 0, 4, 2, 16));      // jalr x4, 16(x2) to 24
  put(3, addi(3, 0, 66));                // skipped
  put(3, addi(10, 0, 10));
  put(3, ecall_word);
  expect_reg(3, 1, 32'd1);
  expect_reg(3, 2, 32'd8);
  expect_reg(3, 3, 32'd5);
  expect_reg(3, 4, 32'd20);
  // ecall without halt code, then the halting one
  names[4] = "ecall_halt";
  put(4, addi(6, 0, 2));
  put(4, addi(7, 0, 3));
  put(4, addi(10, 0, 3));
  put(4, ecall_word);                    // a0 = 3, keeps running
  put(4, addi(5, 0, 21));
  put(4, addi(10, 0, 10));
  put(4, ecall_word);                    // halts here
  put(4, addi(6, 0, 33));
  put(4, addi(7, 0, 44));
  expect_reg(4, 5, 32'd21);
  expect_reg(4, 6, 32'd2);
  expect_reg(4, 7, 32'd3);
  expect_reg(4, 10, 32'd10);
endtask

/* tb_cpu.sv */
// testbench for the rv32i pipeline, runs table programs and checks registers
`timescale 1ns/1ps

module tb_cpu;

  localparam int half_period = 50;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;
  logic        halted;

  int errors;
  int passed;
  int failed;
  int cycle_count;
  int cycle_limit;

  localparam logic [31:0] ecall_word = 32'h0000_0073;

  // instruction encoders, fields taken from the isa layout
  function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    logic [31:0] a7, a3, ad, a1, a2;
    a7 = f7;
    a3 = f3;
    ad = rd;
    a1 = rs1;
    a2 = rs2;
    return {a7[6:0], a2[4:0], a1[4:0], a3[2:0], ad[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input int opc, input int f3, input int rd,
                                         input int rs1, input int imm);
    logic [31:0] ao, a3, ad, a1, m;
    ao = opc;
    a3 = f3;
    ad = rd;
    a1 = rs1;
    m  = imm;
    return {m[11:0], a1[4:0], a3[2:0], ad[4:0], ao[6:0]};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_type(19, 0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    logic [31:0] a2, a1, m;
    a2 = rs2;
    a1 = rs1;
    m  = imm;
    return {m[11:5], a2[4:0], a1[4:0], 3'b010, m[4:0], 7'b0100011};   // sw only
  endfunction

  function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                         input int imm);
    logic [31:0] a3, a1, a2, m;
    a3 = f3;
    a1 = rs1;
    a2 = rs2;
    m  = imm;
    return {m[12], m[10:5], a2[4:0], a1[4:0], a3[2:0], m[4:1], m[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    logic [31:0] ad, m;
    ad = rd;
    m  = imm;
    return {m[20], m[10:1], m[11], m[19:12], ad[4:0], 7'b1101111};
  endfunction

  `include "tb_programs.svh"

  cpu i_cpu (
    .clk, .reset,
    .imem_we, .imem_addr, .imem_data,
    .dbg_addr, .dbg_data,
    .halted
  );

  always #half_period clk = ~clk;

  // global watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run exceeded %0d cycles without finishing", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic run_test(input int t);
    int cycles;
    @(negedge clk);
    reset = 1'b1;
    repeat (10) @(negedge clk);
    for (int i = 0; i < max_words; i++) begin   // program load under reset
      imem_we   = 1'b1;
      imem_addr = 8'(i);
      imem_data = prog[t][i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    reset   = 1'b0;
    cycles  = 0;
    while (!halted && cycles < budget[t]) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("test %s did not halt within %0d cycles", names[t], budget[t]);
    end else begin
      for (int k = 0; k < n_exp[t]; k++) begin
        @(negedge clk);
        dbg_addr = 5'(exp_reg[t][k]);
        #(half_period / 2);             // mid low phase, regs quiet
        check_value(dbg_data, exp_val[t][k], $sformatf("%s x%0d", names[t], exp_reg[t][k]));
      end
    end
  endtask

  initial begin
    int start_errors;
    int max_budget;
    clk         = 1'b0;
    reset       = 1'b1;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_data   = '0;
    dbg_addr    = '0;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    cycle_count = 0;
    cycle_limit = 100000;
    fill_table();
    max_budget = 0;
    for (int t = 0; t < n_tests; t++)
      if (budget[t] > max_budget) max_budget = budget[t];
    // reset, load, run and readback per test plus margin
    cycle_limit = n_tests * (max_budget + 10 + max_words + 4 * 2 + 4) + 50;
    for (int t = 0; t < n_tests; t++) begin
      start_errors = errors;
      run_test(t);
      if (errors == start_errors) begin
        passed++;
        $display("test %s passed", names[t]);
      end else begin
        failed++;
        $display("test %s failed", names[t]);
      end
    end
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
cpu_pkg.sv
cpu_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_sva.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= vlog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
